//--- verilog/kf_pkg.sv
/*
  Shared types, converter constants and the fixed-point helper for the Kalman estimator.
  All values are signed Q16.16. Products keep bits [47:16] of the 64-bit result.
  Every sum wraps at 32 bits. Coefficients are fixed at build time.
*/
`default_nettype none

package kf_pkg;

	typedef logic signed [31:0] fix_t;   // Q16.16, msb is sign
	typedef fix_t vec_t [4];             // state vector or one row of operands
	typedef fix_t mat_t [4][4];          // row-major 4x4

	// per-sample sequence, shared by the sequencer and its checks
	typedef enum logic [3:0] {
		IDLE,
		GEN_A,
		PREDICT,
		ADD_BU,
		CORRECT,
		PUBLISH,
		GEN_PLUS,
		PRED_PLUS,
		BU_PLUS,
		GEN_MINUS,
		PRED_MINUS,
		BU_MINUS,
		DONE
	} seq_state_e;

	localparam fix_t FIX_ONE   = 32'sh0001_0000;  // 1.0
	localparam fix_t DUTY_STEP = 32'sh0000_0007;  // ~0.0001, MPPT perturbation
	localparam fix_t TS_Q      = 32'sh0000_0001;  // sample period, one lsb ~15.3 us

	// continuous-time coefficient magnitudes
	localparam fix_t INV_C     = 32'sh0F06_2762;  // 1/C, ~3846
	localparam fix_t INV_L     = 32'sh00A6_AAAB;  // 1/(L1+L2), ~166.7
	localparam fix_t RC_LOAD   = 32'shF800_0000;  // -1/(Rload*Cout), -2048
	localparam fix_t NEG_INV_C = -INV_C;
	localparam fix_t NEG_INV_L = -INV_L;

	// state order: vcpv, il1, il2, vcout
	// entry(d) = A_BASE + A_SLOPE * d, d already clamped to 0..1
	localparam mat_t A_BASE = '{
		'{NEG_INV_C, NEG_INV_C, 0,         0},
		'{INV_L,     NEG_INV_L, NEG_INV_L, NEG_INV_L},
		'{INV_L,     NEG_INV_L, NEG_INV_L, NEG_INV_L},
		'{0,         0,         INV_C,     RC_LOAD}
	};

	localparam mat_t A_SLOPE = '{
		'{0,     0,         NEG_INV_C, 0},      // only the switched cap coupling moves
		'{INV_L, NEG_INV_L, INV_L,     INV_L},
		'{INV_L, INV_L,     NEG_INV_L, INV_L},
		'{0,     0,         NEG_INV_C, 0}
	};

	// discrete input gain, pv voltage only drives the input cap
	localparam vec_t B_VEC = '{32'sh0000_0F13, 0, 0, 0};

	// steady-state gain, solved offline for the nominal duty
	localparam vec_t KF_GAIN = '{
		32'sh0000_0A3D,   // ~0.04
		32'sh0000_051F,   // ~0.02
		32'sh0000_051F,
		32'sh0000_3333    // ~0.2, measured state gets most of the weight
	};

	localparam vec_t X_INIT = '{32'sh0000_199A, 32'sh0000_199A,
		32'sh0000_199A, 32'sh0000_199A};  // ~0.1 each

	// full signed product, arithmetic shift by the fraction width, keep 32 bits
	function automatic fix_t fix_mul(input fix_t a, input fix_t b);
		logic signed [63:0] prod;
		prod = a * b;
		return fix_t'(prod >>> 16);
	endfunction

endpackage

`default_nettype wire

//--- verilog/kf_ifs.sv
/*
  Internal buses of the estimator.
  mat_vec_if: operands sampled on start, result with a valid pulse one cycle later.
  a_gen_if: done pulses three cycles after start, a_mat holds until the next start.
*/
`default_nettype none

interface mat_vec_if;
	import kf_pkg::*;

	logic start;     // one cycle, operands sampled here
	mat_t matrix;
	vec_t vector;
	vec_t result;    // held until the next start
	logic valid;     // one cycle after start

	modport ctrl (output start, output matrix, output vector, input result, input valid);
	modport unit (input start, input matrix, input vector, output result, output valid);
endinterface

interface a_gen_if;
	import kf_pkg::*;

	logic start;     // one cycle, duty sampled here
	fix_t duty;      // unclamped request
	logic done;      // three cycles after start
	mat_t a_mat;     // discrete A, stable once done is seen

	modport ctrl (output start, output duty, input done, input a_mat);
	modport gen (input start, input duty, output done, output a_mat);
endinterface

`default_nettype wire

//--- verilog/a_matrix_gen.sv
/*
  Discrete A matrix from the duty cycle, I + Ts*(A_BASE + A_SLOPE*d).
  Duty is saturated to 0..1.0 before use. Fixed 3-cycle latency, not pipelined
  for back-to-back starts. a_mat is unknown until the first done after reset.
*/
`default_nettype none

module a_matrix_gen (
	input  logic  i_clk,
	input  logic  i_arst_n,
	a_gen_if.gen  a_bus
);
	import kf_pkg::*;

	fix_t       duty_sat;   // clamp result, combinational
	fix_t       r_duty;     // stage 1, clamped duty
	mat_t       r_cont;     // stage 2, continuous-time entries
	logic [2:0] r_vld;      // one bit per stage

	// saturate to 0..1.0, negative duty means switch never on
	always_comb begin
		if (a_bus.duty < 0)
			duty_sat = '0;
		else if (a_bus.duty > FIX_ONE)
			duty_sat = FIX_ONE;
		else
			duty_sat = a_bus.duty;
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			r_vld <= '0;
		end else begin
			r_vld <= {r_vld[1:0], a_bus.start};   // start walks through the stages
		end
	end

	// datapath, advances only behind a valid stage
	always_ff @(posedge i_clk) begin
		if (a_bus.start) begin
			r_duty <= duty_sat;
		end
		if (r_vld[0]) begin
			for (int r = 0; r < 4; r++) begin
				for (int c = 0; c < 4; c++) begin
					r_cont[r][c] <= fix_mul(A_SLOPE[r][c], r_duty) + A_BASE[r][c];
				end
			end
		end
		if (r_vld[1]) begin
			// forward euler, identity on the diagonal
			for (int r = 0; r < 4; r++) begin
				for (int c = 0; c < 4; c++) begin
					a_bus.a_mat[r][c] <= fix_mul(r_cont[r][c], TS_Q) +
						((r == c) ? FIX_ONE : fix_t'(0));
				end
			end
		end
	end

	assign a_bus.done = r_vld[2];   // a_mat was written on the same edge

endmodule

`default_nettype wire

//--- verilog/mat_vec_unit.sv
/*
  Shared 4x4 matrix times vector array, sixteen Q16.16 multipliers.
  Each row is the 32-bit wrapped sum of four truncated products.
  One new operation per cycle, result registered with a one-cycle valid.
*/
`default_nettype none

module mat_vec_unit (
	input  logic     i_clk,
	input  logic     i_arst_n,
	mat_vec_if.unit  mv
);
	import kf_pkg::*;

	mat_t prod;      // one lane per matrix entry
	vec_t row_sum;   // wraps at 32 bits

	always_comb begin
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				prod[r][c] = fix_mul(mv.matrix[r][c], mv.vector[c]);
			end
		end
	end

	always_comb begin
		for (int r = 0; r < 4; r++) begin
			row_sum[r] = prod[r][0] + prod[r][1] + prod[r][2] + prod[r][3];
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			mv.valid <= 1'b0;
		end else begin
			mv.valid <= mv.start;   // single pulse per start
		end
	end

	// result holds between starts
	always_ff @(posedge i_clk) begin
		if (mv.start) begin
			mv.result <= row_sum;
		end
	end

endmodule

`default_nettype wire

//--- verilog/kf_sequencer.sv
/*
  Per-sample sequencer: A rebuild, predict, fixed-gain correct, then the
  duty +/- step predictions from the corrected state. Strobes are ignored
  while busy. Outputs change only together with o_dv.
*/
`default_nettype none

module kf_sequencer (
	input  logic          i_clk,
	input  logic          i_arst_n,
	input  logic          i_begin,      // sample strobe
	input  kf_pkg::fix_t  i_u,          // pv voltage
	input  kf_pkg::fix_t  i_y,          // output voltage
	input  kf_pkg::fix_t  i_duty,       // requested duty, clamped downstream
	a_gen_if.ctrl         a_bus,
	mat_vec_if.ctrl       mv,
	output kf_pkg::vec_t  o_state,      // vcpv, il1, il2, vcout
	output kf_pkg::fix_t  o_ipv,
	output kf_pkg::fix_t  o_ipv_plus,
	output kf_pkg::fix_t  o_ipv_minus,
	output logic          o_dv,
	output logic          o_busy
);
	import kf_pkg::*;

	seq_state_e r_state;
	vec_t       r_x;           // estimate, carried across samples
	vec_t       r_scr;         // scratch for the +/- predictions
	vec_t       bu;            // B*u
	fix_t       r_u;
	fix_t       r_y;
	fix_t       r_duty;        // latched duty, base for the +/- steps
	fix_t       r_duty_use;    // duty handed to the A generator
	fix_t       r_ipv;         // corrected-sample pv current
	fix_t       r_ipv_plus;
	fix_t       innov;         // y - C*x, C picks vcout
	logic       r_gen_start;
	logic       a_ready;       // A matrix for this pass is ready

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			bu[i] = fix_mul(B_VEC[i], r_u);
		end
	end

	assign innov   = r_y - r_x[3];
	assign a_ready = a_bus.done && (r_state inside {GEN_A, GEN_PLUS, GEN_MINUS});

	assign a_bus.start = r_gen_start;
	assign a_bus.duty  = r_duty_use;

	// A*X always uses the current estimate, predict runs on the cycle A is done
	assign mv.start  = a_ready;
	assign mv.matrix = a_bus.a_mat;
	assign mv.vector = r_x;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			r_state     <= IDLE;
			r_gen_start <= 1'b0;
			r_x         <= X_INIT;
			o_state     <= '{default: '0};
			o_ipv       <= '0;
			o_ipv_plus  <= '0;
			o_ipv_minus <= '0;
			o_dv        <= 1'b0;
			o_busy      <= 1'b0;
		end else begin
			r_gen_start <= 1'b0;   // pulse
			o_dv        <= 1'b0;
			case (r_state)
				IDLE: begin
					if (i_begin) begin
						r_gen_start <= 1'b1;
						o_busy      <= 1'b1;
						r_state     <= GEN_A;
					end
				end
				GEN_A: begin
					if (a_ready)
						r_state <= PREDICT;
				end
				PREDICT: begin
					if (mv.valid) begin
						r_x     <= mv.result;   // A*X
						r_state <= ADD_BU;
					end
				end
				ADD_BU: begin
					for (int i = 0; i < 4; i++) begin
						r_x[i] <= r_x[i] + bu[i];
					end
					r_state <= CORRECT;
				end
				CORRECT: begin
					for (int i = 0; i < 4; i++) begin
						r_x[i] <= r_x[i] + fix_mul(KF_GAIN[i], innov);
					end
					r_state <= PUBLISH;
				end
				PUBLISH: begin
					r_gen_start <= 1'b1;   // A at duty + step
					r_state     <= GEN_PLUS;
				end
				GEN_PLUS: begin
					if (a_ready)
						r_state <= PRED_PLUS;
				end
				PRED_PLUS: begin
					if (mv.valid)
						r_state <= BU_PLUS;
				end
				BU_PLUS: begin
					r_gen_start <= 1'b1;   // A at duty - step
					r_state     <= GEN_MINUS;
				end
				GEN_MINUS: begin
					if (a_ready)
						r_state <= PRED_MINUS;
				end
				PRED_MINUS: begin
					if (mv.valid)
						r_state <= BU_MINUS;
				end
				BU_MINUS: begin
					r_state <= DONE;
				end
				DONE: begin
					o_state     <= r_x;
					o_ipv       <= r_ipv;
					o_ipv_plus  <= r_ipv_plus;
					o_ipv_minus <= r_u - r_scr[0];
					o_dv        <= 1'b1;
					o_busy      <= 1'b0;   // falls with o_dv
					r_state     <= IDLE;
				end
				default: begin
					r_state <= IDLE;
				end
			endcase
		end
	end

	// sample and scratch registers, only meaningful while busy
	always_ff @(posedge i_clk) begin
		case (r_state)
			IDLE: begin
				if (i_begin) begin
					r_u        <= i_u;
					r_y        <= i_y;
					r_duty     <= i_duty;
					r_duty_use <= i_duty;
				end
			end
			PUBLISH: begin
				r_ipv      <= r_u - r_x[0];   // ipv = vpv - vcpv
				r_duty_use <= r_duty + DUTY_STEP;
			end
			PRED_PLUS: begin
				if (mv.valid) begin
					r_scr      <= mv.result;
					r_duty_use <= r_duty - DUTY_STEP;
				end
			end
			PRED_MINUS: begin
				if (mv.valid)
					r_scr <= mv.result;
			end
			BU_PLUS, BU_MINUS: begin
				for (int i = 0; i < 4; i++) begin
					r_scr[i] <= r_scr[i] + bu[i];
				end
			end
			GEN_MINUS: begin
				if (a_ready)
					r_ipv_plus <= r_u - r_scr[0];   // before minus pass overwrites scratch
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/kalman_top.sv
/*
  Steady-state Kalman estimator for a two-inductor boost converter.
  All data ports are signed Q16.16. i_begin is accepted only while o_busy is low,
  results appear with a one-cycle o_dv and hold until the next one.
*/
`default_nettype none

module kalman_top (
	input  logic          i_clk,
	input  logic          i_arst_n,
	input  logic          i_begin,
	input  kf_pkg::fix_t  i_u,           // pv voltage
	input  kf_pkg::fix_t  i_y,           // measured output voltage
	input  kf_pkg::fix_t  i_duty,
	output kf_pkg::fix_t  o_state0,      // vcpv
	output kf_pkg::fix_t  o_state1,      // il1
	output kf_pkg::fix_t  o_state2,      // il2
	output kf_pkg::fix_t  o_state3,      // vcout
	output kf_pkg::fix_t  o_ipv,
	output kf_pkg::fix_t  o_ipv_plus,    // prediction at duty + step
	output kf_pkg::fix_t  o_ipv_minus,   // prediction at duty - step
	output logic          o_dv,
	output logic          o_busy
);
	import kf_pkg::*;

	vec_t state_vec;

	a_gen_if   a_bus ();
	mat_vec_if mv ();

	kf_sequencer u_seq (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.i_begin     (i_begin),
		.i_u         (i_u),
		.i_y         (i_y),
		.i_duty      (i_duty),
		.a_bus       (a_bus),
		.mv          (mv),
		.o_state     (state_vec),
		.o_ipv       (o_ipv),
		.o_ipv_plus  (o_ipv_plus),
		.o_ipv_minus (o_ipv_minus),
		.o_dv        (o_dv),
		.o_busy      (o_busy)
	);

	a_matrix_gen u_a_gen (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.a_bus    (a_bus)
	);

	mat_vec_unit u_mv (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.mv       (mv)
	);

	assign o_state0 = state_vec[0];
	assign o_state1 = state_vec[1];
	assign o_state2 = state_vec[2];
	assign o_state3 = state_vec[3];

endmodule

`default_nettype wire

//--- verif/kalman_sva.sv
/*
  Protocol checks on the estimator top level, bound into kalman_top.
  Covers the o_dv pulse shape and the o_busy handshake, not the datapath.
*/
`default_nettype none

module kalman_sva (
	input  logic  i_clk,
	input  logic  i_arst_n,
	input  logic  i_begin,
	input  logic  o_busy,
	input  logic  o_dv
);

	// result strobe lasts one cycle
	a_dv_single: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_dv |=> !o_dv)
		else $error("o_dv stayed high for more than one cycle");

	// busy drops on the same edge that raises o_dv
	a_dv_busy_fall: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_dv |-> (!o_busy && $past(o_busy)))
		else $error("o_dv without o_busy falling in the same cycle");

	// busy only starts from an accepted strobe
	a_busy_cause: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		$rose(o_busy) |-> $past(i_begin && !o_busy))
		else $error("o_busy rose without an accepted i_begin");

endmodule

`default_nettype wire

//--- verif/tb_kalman_top.sv
/*
  Testbench for kalman_top, seeded random samples checked against a Q16.16 model.
  Inputs change on the falling edge, outputs are read on the falling edge.
  Stops at the first mismatch. The model keeps its own state vector.
*/
`default_nettype none

module tb_kalman_top;
	import kf_pkg::*;

	localparam int SEED      = 42256;
	localparam int N_SAMPLES = 206;                          // 201 random, 2 clamp, 3 drop
	localparam int CYC_BOUND = 40;                           // per-sample cycle budget
	localparam int WD_TIME   = (N_SAMPLES + 10) * CYC_BOUND * 4 * 2;

	logic i_clk = 1'b0;
	logic i_arst_n;
	logic i_begin;
	fix_t i_u, i_y, i_duty;
	fix_t o_state0, o_state1, o_state2, o_state3;
	fix_t o_ipv, o_ipv_plus, o_ipv_minus;
	logic o_dv, o_busy;

	mat_t m_a;                    // model discrete A for the current pass
	vec_t m_x;                    // model estimate
	vec_t m_s;                    // model prediction scratch
	fix_t exp_ipv = '0;
	fix_t exp_plus = '0;
	fix_t exp_minus = '0;
	fix_t s_u, s_y, s_duty;       // next sample
	int   dv_count = 0;
	int   n_done = 0;

	kalman_top u_kalman_top (.*);

	bind kalman_top kalman_sva u_sva (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_begin(i_begin),
		.o_busy(o_busy), .o_dv(o_dv)
	);

	always #2 i_clk = ~i_clk;

	always @(posedge i_clk) begin
		if (o_dv)
			dv_count <= dv_count + 1;   // every result strobe, wanted or not
	end

	initial begin
		#(WD_TIME);
		$display("watchdog expired, the DUT stopped producing results");
		$display("Something failed");
		$fatal(1);
	end

	task automatic compare_value(input string name, input fix_t exp, input fix_t act);
		if (exp !== act) begin
			$display("error: %s expected %h got %h", name, exp, act);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	// I + Ts*(base + slope*d), duty saturated first
	task automatic build_a(input fix_t duty);
		fix_t d;
		fix_t cont;
		d = (duty < 0) ? fix_t'(0) : ((duty > FIX_ONE) ? FIX_ONE : duty);
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				cont = fix_mul(A_SLOPE[r][c], d) + A_BASE[r][c];
				m_a[r][c] = fix_mul(cont, TS_Q) + ((r == c) ? FIX_ONE : fix_t'(0));
			end
		end
	endtask

	// m_s = A*x + B*u, all sums wrap at 32 bits
	task automatic predict(input fix_t u);
		fix_t acc;
		for (int r = 0; r < 4; r++) begin
			acc = '0;
			for (int c = 0; c < 4; c++)
				acc = acc + fix_mul(m_a[r][c], m_x[c]);
			m_s[r] = acc + fix_mul(B_VEC[r], u);
		end
	endtask

	task automatic model_sample(input fix_t u, input fix_t y, input fix_t duty);
		fix_t innov;
		build_a(duty);
		predict(u);
		m_x = m_s;
		innov = y - m_x[3];       // C selects the output cap voltage
		for (int i = 0; i < 4; i++)
			m_x[i] = m_x[i] + fix_mul(KF_GAIN[i], innov);
		exp_ipv = u - m_x[0];
		build_a(duty + DUTY_STEP);   // scratch only, m_x untouched
		predict(u);
		exp_plus = u - m_s[0];
		build_a(duty - DUTY_STEP);
		predict(u);
		exp_minus = u - m_s[0];
	endtask

	// called on a falling edge, returns on the falling edge that shows o_dv
	task automatic run_sample(input bit inject);
		i_u = s_u;
		i_y = s_y;
		i_duty = s_duty;
		i_begin = 1'b1;
		@(negedge i_clk);
		i_begin = 1'b0;
		compare_value("o_busy", fix_t'(1), fix_t'(o_busy));
		compare_value("dv_count", n_done, dv_count);
		compare_value("o_ipv", exp_ipv, o_ipv);   // previous result still held
		model_sample(s_u, s_y, s_duty);
		do begin
			i_begin = 1'b0;
			if (inject && o_busy) begin
				i_begin = 1'($urandom_range(0, 1));   // must be dropped
				i_u = $urandom;
				i_y = $urandom;
				i_duty = $urandom;
			end
			@(negedge i_clk);
		end while (!o_dv);
		i_begin = 1'b0;
		compare_value("o_busy", fix_t'(0), fix_t'(o_busy));
		compare_value("o_state0", m_x[0], o_state0);
		compare_value("o_state1", m_x[1], o_state1);
		compare_value("o_state2", m_x[2], o_state2);
		compare_value("o_state3", m_x[3], o_state3);
		compare_value("o_ipv", exp_ipv, o_ipv);
		compare_value("o_ipv_plus", exp_plus, o_ipv_plus);
		compare_value("o_ipv_minus", exp_minus, o_ipv_minus);
		n_done++;
	endtask

	task automatic pick_inputs();
		s_u = fix_t'($urandom_range(0, 32'h0028_0000));     // 0..40 V
		s_y = fix_t'($urandom_range(0, 32'h0050_0000));     // 0..80 V
		s_duty = fix_t'($urandom_range(0, 32'h0001_0000));  // 0..1.0
	endtask

	initial begin
		void'($urandom(SEED));
		i_arst_n = 1'b0;
		i_begin = 1'b0;
		i_u = '0;
		i_y = '0;
		i_duty = '0;
		m_x = X_INIT;
		repeat (3) @(negedge i_clk);
		i_arst_n = 1'b1;
		@(negedge i_clk);
		compare_value("o_dv", fix_t'(0), fix_t'(o_dv));
		compare_value("o_busy", fix_t'(0), fix_t'(o_busy));
		compare_value("o_state0", '0, o_state0);
		compare_value("o_state1", '0, o_state1);
		compare_value("o_state2", '0, o_state2);
		compare_value("o_state3", '0, o_state3);
		compare_value("o_ipv", '0, o_ipv);
		compare_value("o_ipv_plus", '0, o_ipv_plus);
		compare_value("o_ipv_minus", '0, o_ipv_minus);
		for (int n = 0; n < 201; n++) begin   // first sample, then carried state
			pick_inputs();
			run_sample(1'b0);
		end
		pick_inputs();
		s_duty = -fix_t'($urandom_range(1, 32'h0001_0000));   // behaves as 0
		run_sample(1'b0);
		pick_inputs();
		s_duty = FIX_ONE + fix_t'($urandom_range(1, 32'h0001_0000));   // behaves as 1.0
		run_sample(1'b0);
		repeat (3) begin   // strobes while busy
			pick_inputs();
			run_sample(1'b1);
		end
		@(negedge i_clk);
		compare_value("dv_count", n_done, dv_count);
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
verilog/kf_pkg.sv
verilog/kf_ifs.sv
verilog/a_matrix_gen.sv
verilog/mat_vec_unit.sv
verilog/kf_sequencer.sv
verilog/kalman_top.sv
verif/kalman_sva.sv
verif/tb_kalman_top.sv

//--- run.sh
#!/bin/sh
# build and run the testbench, exit status carries the result
verilator --binary --timing --assert -f flist.f --top-module tb_kalman_top \
	-o tb_kalman_top \
	&& ./obj_dir/tb_kalman_top \
	|| exit 1
